// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_conv
FILELIST = verilog.f
BUILD    = obj_dir
LOG      = sim.log
PASS     = NO ERRORS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL), run $(TOP) and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) | tee $(LOG)
	@grep -qx "$(PASS)" $(LOG) && echo "test passed" || { echo "test failed"; exit 1; }

clean:
	rm -rf $(BUILD) $(LOG)

// ==== source/conv_engine.sv ====
`timescale 1ns/100ps

module conv_engine
    import img_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    patch_if.receiver in,
    output logic      res_valid,
    input  logic      res_ready,
    output result_t   res_data,
    output coord_t    res_row,
    output coord_t    res_col,
    output logic      res_last
);

    result_t sum;
    logic    accept;

    assign accept = res_valid && res_ready;

    // pixels are unsigned, so widen with a zero sign bit first
    always_comb
    begin
        sum = '0;
        for (int c = 0; c < 3; c++)
            for (int r = 0; r < 3; r++)
                sum += result_t'($signed({1'b0, in.patch.pix[c*3 + r]}))
                     * result_t'(kernel[r][c]);
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            res_valid <= 1'b0;
        else if (in.valid)
            res_valid <= 1'b1;                   // slot was free when popped
        else if (res_ready)
            res_valid <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (in.valid)
        begin
            res_data <= sum;
            res_row  <= in.patch.row;
            res_col  <= in.patch.col;
            res_last <= in.patch.last;
        end
    end

    assign in.credit    = accept;                // holding slot is free again
    assign in.last_seen = accept && res_last;

endmodule

// ==== source/conv_top.sv ====
`timescale 1ns/100ps

module conv_top
    import img_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      wr_en,
    input  pix_addr_t wr_addr,
    input  pixel_t    wr_data,
    input  logic      start,
    output logic      busy,
    output logic      res_valid,
    input  logic      res_ready,
    output result_t   res_data,
    output coord_t    res_row,
    output coord_t    res_col,
    output logic      res_last
);

    pix_addr_t [8:0] rd_addr;
    pixel_t    [8:0] rd_data;

    patch_if prod_q ();                          // producer to buffer
    patch_if cons_q ();                          // buffer to MAC

    image_ram ram0 (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    window_producer prod0 (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .busy    (busy),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .out     (prod_q.sender)
    );

    patch_fifo fifo0 (
        .clk (clk),
        .rst (rst),
        .in  (prod_q.receiver),
        .out (cons_q.sender)
    );

    conv_engine mac0 (
        .clk       (clk),
        .rst       (rst),
        .in        (cons_q.receiver),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res_data  (res_data),
        .res_row   (res_row),
        .res_col   (res_col),
        .res_last  (res_last)
    );

endmodule

// ==== source/flow_pkg.sv ====
package flow_pkg;

    import img_pkg::*;

    localparam int buf_depth = 4;               // patch slots in the buffer
    localparam int credit_w  = 3;               // holds 0 .. buf_depth

    // pixels are column-major: pix[col*3 + row]
    typedef struct packed {
        pixel_t [8:0] pix;
        coord_t       row;
        coord_t       col;
        logic         last;                     // final window of the frame
    } patch_t;

endpackage

// ==== source/image_ram.sv ====
`timescale 1ns/100ps

module image_ram
    import img_pkg::*;
(
    input  logic              clk,
    input  logic              wr_en,
    input  pix_addr_t         wr_addr,
    input  pixel_t            wr_data,
    input  pix_addr_t [8:0]   rd_addr,
    output pixel_t    [8:0]   rd_data
);

    pixel_t mem [img_h*img_w];

    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
    end

    // nine taps read at once, no read latency
    always_comb
    begin
        for (int k = 0; k < 9; k++)
            rd_data[k] = mem[rd_addr[k]];
    end

endmodule

// ==== source/img_pkg.sv ====
package img_pkg;

    localparam int img_h   = 28;
    localparam int img_w   = 28;
    localparam int pix_w   = 8;                 // unsigned greyscale
    localparam int addr_w  = 10;                // covers img_h * img_w
    localparam int coord_w = 5;
    localparam int kern_w  = 5;                 // signed, wide enough for the +8 centre tap
    localparam int res_w   = 16;

    typedef logic [pix_w-1:0]          pixel_t;
    typedef logic [addr_w-1:0]         pix_addr_t;
    typedef logic [coord_w-1:0]        coord_t;
    typedef logic signed [kern_w-1:0]  weight_t;
    typedef logic signed [res_w-1:0]   result_t;

    // edge detector, indexed kernel[row][col]
    localparam weight_t kernel [3][3] = '{
        '{-1, -1, -1},
        '{-1,  8, -1},
        '{-1, -1, -1}
    };

endpackage

// ==== source/patch_addr_gen.sv ====
`timescale 1ns/100ps

module patch_addr_gen
    import img_pkg::*;
#(
    parameter int img_h = img_pkg::img_h,
    parameter int img_w = img_pkg::img_w
)
(
    input  logic              clk,
    input  logic              rst,
    input  logic              addr,             // centre strobe
    input  coord_t            i,
    input  coord_t            j,
    output pix_addr_t [8:0]   pixel_addr,
    output logic      [8:0]   pad_mask,
    output logic              load_full_patch
);

    coord_t          prev_i;
    logic            row_chg;
    pix_addr_t [8:0] addr_nxt;
    logic      [8:0] pad_nxt;

    function automatic logic in_image(int r, int c);
        return r >= 0 && r < img_h && c >= 0 && c < img_w;
    endfunction

    assign row_chg = (i != prev_i);

    // tap k sits at row k%3, column k/3 of the window
    always_comb
    begin
        int r;
        int c;
        for (int k = 0; k < 9; k++)
        begin
            r = int'(i) - 1 + k % 3;            // top edge is centre minus one
            c = int'(j) - 1 + k / 3;
            pad_nxt[k]  = !in_image(r, c);
            addr_nxt[k] = pad_nxt[k] ? '0 : pix_addr_t'(r * img_w + c);
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            prev_i          <= '1;              // no valid row yet
            load_full_patch <= 1'b1;
        end
        else if (addr)
        begin
            prev_i          <= i;
            load_full_patch <= row_chg;
        end
    end

    always_ff @(posedge clk)
    begin
        if (addr)
        begin
            pixel_addr[8:6] <= addr_nxt[8:6];   // right column, every window
            pad_mask[8:6]   <= pad_nxt[8:6];
            if (row_chg)
            begin
                pixel_addr[5:0] <= addr_nxt[5:0];
                pad_mask[5:0]   <= pad_nxt[5:0];
            end
        end
    end

endmodule

// ==== source/patch_fifo.sv ====
`timescale 1ns/100ps

module patch_fifo
    import flow_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    patch_if.receiver in,
    patch_if.sender   out
);

    patch_t                       mem [buf_depth];
    logic [$clog2(buf_depth)-1:0] wr_ptr;
    logic [$clog2(buf_depth)-1:0] rd_ptr;
    logic [credit_w-1:0]          fill;
    logic                         dn_credit;     // consumer holds a single slot
    logic                         pop;

    assign pop = fill != '0 && dn_credit;

    assign out.valid    = pop;
    assign out.patch    = mem[rd_ptr];
    assign in.credit    = pop;                   // slot freed upstream
    assign in.last_seen = out.last_seen;         // final result has been taken

    always_ff @(posedge clk)
    begin
        if (in.valid)
            mem[wr_ptr] <= in.patch;             // credits guarantee room
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            fill      <= '0;
            dn_credit <= 1'b1;
        end
        else
        begin
            if (in.valid)
                wr_ptr <= (int'(wr_ptr) == buf_depth - 1) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (int'(rd_ptr) == buf_depth - 1) ? '0 : rd_ptr + 1'b1;
            fill      <= fill + credit_w'(in.valid) - credit_w'(pop);
            dn_credit <= (dn_credit && !pop) || out.credit;
        end
    end

endmodule

// ==== source/patch_if.sv ====
`timescale 1ns/100ps

interface patch_if
    import flow_pkg::*;
();

    logic   valid;                              // one patch per pulse
    patch_t patch;
    logic   credit;                             // one freed slot per pulse
    logic   last_seen;                          // frame's final patch is done

    modport sender (
        output valid,
        output patch,
        input  credit,
        input  last_seen
    );

    modport receiver (
        input  valid,
        input  patch,
        output credit,
        output last_seen
    );

endinterface

// ==== source/window_producer.sv ====
`timescale 1ns/100ps

module window_producer
    import img_pkg::*;
    import flow_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    output logic              busy,
    output pix_addr_t [8:0]   rd_addr,
    input  pixel_t    [8:0]   rd_data,
    patch_if.sender           out
);

    logic [credit_w-1:0] credits;
    coord_t              scan_i;
    coord_t              scan_j;
    logic                scanning;              // centres left to strobe
    logic                strobe;
    logic                at_last;
    logic [8:0]          pad_mask;
    logic                load_full;
    logic                push;
    coord_t              pend_row;
    coord_t              pend_col;
    logic                pend_last;
    pixel_t [8:0]        fresh;
    patch_t              next_patch;
    patch_t              prev_patch;

    assign at_last = scan_i == coord_t'(img_h - 1) && scan_j == coord_t'(img_w - 1);
    assign strobe  = scanning && credits != '0; // reserves the slot now, pushes next cycle

    patch_addr_gen addr_gen0 (
        .clk             (clk),
        .rst             (rst),
        .addr            (strobe),
        .i               (scan_i),
        .j               (scan_j),
        .pixel_addr      (rd_addr),
        .pad_mask        (pad_mask),
        .load_full_patch (load_full)
    );

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            credits  <= credit_w'(buf_depth);
            busy     <= 1'b0;
            scanning <= 1'b0;
            scan_i   <= '0;
            scan_j   <= '0;
            push     <= 1'b0;
        end
        else
        begin
            credits <= credits - credit_w'(strobe) + credit_w'(out.credit);
            push    <= strobe;
            if (start && !busy)
            begin
                busy     <= 1'b1;
                scanning <= 1'b1;
                scan_i   <= '0;
                scan_j   <= '0;
            end
            else if (out.last_seen)
                busy <= 1'b0;
            if (strobe)
            begin
                if (at_last)
                    scanning <= 1'b0;
                else if (scan_j == coord_t'(img_w - 1))
                begin
                    scan_j <= '0;
                    scan_i <= scan_i + 1'b1;
                end
                else
                    scan_j <= scan_j + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (strobe)
        begin
            pend_row  <= scan_i;
            pend_col  <= scan_j;
            pend_last <= at_last;
        end
        if (push)
            prev_patch <= next_patch;
    end

    always_comb
    begin
        for (int k = 0; k < 9; k++)
            fresh[k] = pad_mask[k] ? '0 : rd_data[k];  // padding reads as zero
        next_patch.row  = pend_row;
        next_patch.col  = pend_col;
        next_patch.last = pend_last;
        if (load_full)
            next_patch.pix = fresh;
        else
        begin
            next_patch.pix[5:0] = prev_patch.pix[8:3];   // slide one column left
            next_patch.pix[8:6] = fresh[8:6];
        end
    end

    assign out.valid = push;
    assign out.patch = next_patch;

endmodule

// ==== verif/tb_conv.sv ====
`timescale 1ns/100ps

module tb_conv
    import img_pkg::*;
();

    localparam int npix        = img_h * img_w;
    localparam int clk_ns      = 100;
    localparam int stall_limit = 200;                       // cycles without a result
    localparam int watchdog_ns = 4 * npix * 20 * clk_ns;

    logic      clk;
    logic      rst;
    logic      wr_en;
    pix_addr_t wr_addr;
    pixel_t    wr_data;
    logic      start;
    logic      busy;
    logic      res_valid;
    logic      res_ready;
    result_t   res_data;
    coord_t    res_row;
    coord_t    res_col;
    logic      res_last;

    pixel_t      img [npix];                                // copy of the image in the RAM
    result_t     exp_res [npix];
    logic [31:0] lcg_state = 32'h408d_b669;
    int          err_count = 0;
    int          fail_count = 0;

    conv_top dut0 (
        .clk       (clk),
        .rst       (rst),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .start     (start),
        .busy      (busy),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res_data  (res_data),
        .res_row   (res_row),
        .res_col   (res_col),
        .res_last  (res_last)
    );

    initial
    begin
        clk = 1'b0;
        forever #(clk_ns / 2) clk = ~clk;
    end

    initial
    begin
        #(watchdog_ns);
        $display("timeout: the tests did not finish within %0d ns", watchdog_ns);
        $display("ERRORS FOUND");
        $finish;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int padded_neighbours(int r, int c);
        int cnt;
        cnt = 0;
        for (int dr = -1; dr <= 1; dr++)
            for (int dc = -1; dc <= 1; dc++)
                if (r + dr < 0 || r + dr >= img_h || c + dc < 0 || c + dc >= img_w)
                    cnt++;
        return cnt;
    endfunction

    task automatic check_result(input result_t got, input result_t exp, input string what);
        if (got !== exp)
        begin
            err_count++;
            $display("error at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_coord(input coord_t got, input coord_t exp, input string what);
        if (got !== exp)
        begin
            err_count++;
            $display("error at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            err_count++;
            $display("error at %0d ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic apply_reset();
        rst = 1'b0;
        repeat (10) @(posedge clk);
        #10 rst = 1'b1;
    endtask

    // mode 0 all zero, 1 constant 10, 2 random
    task automatic load_image(input int mode);
        logic [31:0] rnd;
        for (int a = 0; a < npix; a++)
        begin
            rnd = next_rand();
            img[a] = (mode == 0) ? pixel_t'(0) : (mode == 1) ? pixel_t'(10) : rnd[31:24];
            @(posedge clk);
            #10;
            wr_en   = 1'b1;
            wr_addr = pix_addr_t'(a);
            wr_data = img[a];
        end
        @(posedge clk);
        #10 wr_en = 1'b0;
    endtask

    // zero padded 3x3 convolution of the image copy
    task automatic build_reference();
        int sum;
        int rr;
        int cc;
        for (int r = 0; r < img_h; r++)
            for (int c = 0; c < img_w; c++)
            begin
                sum = 0;
                for (int dr = 0; dr < 3; dr++)
                    for (int dc = 0; dc < 3; dc++)
                    begin
                        rr = r - 1 + dr;
                        cc = c - 1 + dc;
                        if (rr >= 0 && rr < img_h && cc >= 0 && cc < img_w)
                            sum += int'(img[rr * img_w + cc]) * int'(kernel[dr][dc]);
                    end
                exp_res[r * img_w + c] = result_t'(sum);
            end
    endtask

    task automatic run_frame(input bit random_ready, input bit restart);
        logic [31:0] rnd;
        int          n;
        int          stall;
        int          cyc;
        bit          done;
        bit          restart_sent;
        n = 0;
        stall = 0;
        cyc = 0;
        done = 0;
        restart_sent = 0;
        @(posedge clk);
        #10;
        start = 1'b1;
        res_ready = 1'b1;
        while (!done && stall < stall_limit)
        begin
            @(negedge clk);
            if (cyc == 1)
                check_flag(busy, 1'b1, "busy after start");
            if (res_valid && res_ready && n < npix)
            begin
                check_result(res_data, exp_res[n], $sformatf("result %0d value", n));
                check_coord(res_row, coord_t'(n / img_w), $sformatf("result %0d row", n));
                check_coord(res_col, coord_t'(n % img_w), $sformatf("result %0d col", n));
                check_flag(res_last, n == npix - 1, $sformatf("result %0d last", n));
                check_flag(busy, 1'b1, $sformatf("result %0d busy", n));
                done = res_last || n == npix - 1;
                n++;
                stall = 0;
            end
            else
                stall++;
            @(posedge clk);
            #10;
            cyc++;
            rnd = next_rand();
            start = restart && n == 100 && !restart_sent;   // ignored while busy
            restart_sent |= start;
            res_ready = random_ready ? rnd[28] : 1'b1;
        end
        res_ready = 1'b1;
        if (!done)
        begin
            fail_count++;
            $display("frame stalled: no result for %0d cycles after %0d results", stall, n);
        end
        else
        begin
            if (n != npix)
            begin
                fail_count++;
                $display("frame ended after %0d results instead of %0d", n, npix);
            end
            @(negedge clk);
            check_flag(busy, 1'b0, "busy after the last result");
            repeat (10)
            begin
                if (res_valid)
                begin
                    fail_count++;
                    $display("an extra result appeared after the last one at %0d ns", $time);
                end
                @(negedge clk);
            end
        end
    endtask

    task automatic test_zero_image();
        load_image(0);
        build_reference();
        run_frame(1'b0, 1'b0);
    endtask

    // each padded neighbour drops one -10 term, so the sum is 10 per padded tap
    task automatic test_constant_image();
        load_image(1);
        for (int r = 0; r < img_h; r++)
            for (int c = 0; c < img_w; c++)
                exp_res[r * img_w + c] = result_t'(10 * padded_neighbours(r, c));
        run_frame(1'b0, 1'b0);
    endtask

    task automatic test_random_image();
        load_image(2);
        build_reference();
        run_frame(1'b0, 1'b0);
    endtask

    task automatic test_random_backpressure();
        run_frame(1'b1, 1'b0);
    endtask

    // reset lands mid frame while the first result is held
    task automatic test_reset_and_restart();
        int wait_cyc;
        wait_cyc = 0;
        @(posedge clk);
        #10;
        start = 1'b1;
        res_ready = 1'b0;
        @(posedge clk);
        #10 start = 1'b0;
        while (!res_valid && wait_cyc < stall_limit)
        begin
            @(posedge clk);
            #10;
            wait_cyc++;
        end
        if (!res_valid)
        begin
            fail_count++;
            $display("no result appeared within %0d cycles before the reset", wait_cyc);
        end
        check_flag(busy, 1'b1, "busy before reset");
        apply_reset();
        @(negedge clk);
        check_flag(busy, 1'b0, "busy after reset");
        check_flag(res_valid, 1'b0, "res_valid after reset");
        run_frame(1'b0, 1'b1);
        run_frame(1'b1, 1'b0);
    endtask

    initial
    begin
        rst       = 1'b0;
        wr_en     = 1'b0;
        wr_addr   = '0;
        wr_data   = '0;
        start     = 1'b0;
        res_ready = 1'b0;
        apply_reset();
        test_zero_image();
        test_constant_image();
        test_random_image();
        test_random_backpressure();
        test_reset_and_restart();
        $display("summary: %0d value errors, %0d other failures", err_count, fail_count);
        if (err_count == 0 && fail_count == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== verilog.f ====
source/img_pkg.sv
source/flow_pkg.sv
source/patch_if.sv
source/image_ram.sv
source/patch_addr_gen.sv
source/window_producer.sv
source/patch_fifo.sv
source/conv_engine.sv
source/conv_top.sv
verif/tb_conv.sv
